//--- Bender.yml
package:
  name: sbtgt_repeater

sources:
  - design/sbtgt_pkg.sv
  - design/sbtgt_flit_if.sv
  - design/sbtgt_queue.sv
  - design/sbtgt_byte_counter.sv
  - design/sbtgt_msg_tracker.sv
  - design/sbtgt_flow_ctrl.sv
  - design/sbtgt_repeater.sv
  - target: test
    files:
      - tests/sbtgt_tb.sv

//--- design/sbtgt_byte_counter.sv
// beat counter that marks the last byte lane of a dword when the payload is narrower than 32 bits
`timescale 1ns/1ps

module sbtgt_byte_counter #(
  parameter int PLD_WIDTH = sbtgt_pkg::PLD_WIDTH_DEFAULT
) (
  input  logic agent_clk,
  input  logic agent_rst_b,
  input  logic beat,
  output logic last_byte
);

  import sbtgt_pkg::*;

  // 1 beat at width 32, 2 at 16, 4 at 8
  localparam beat_cnt_t LAST_BEAT = beat_cnt_t'((32 / PLD_WIDTH) - 1);

  beat_cnt_t cnt;

  always_ff @(posedge agent_clk or negedge agent_rst_b) begin
    if (!agent_rst_b) begin
      cnt <= '0;
    end else if (beat) begin
      if (cnt == LAST_BEAT) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + beat_cnt_t'(1);
      end
    end
  end

  // with a full dword per beat the count never leaves 0, so this stays high
  assign last_byte = (cnt == LAST_BEAT);

endmodule

//--- design/sbtgt_flit_if.sv
// flit bundle for one sideband channel, driven through src and sampled through dst
`timescale 1ns/1ps

interface sbtgt_flit_if #(
  parameter int PLD_WIDTH = sbtgt_pkg::PLD_WIDTH_DEFAULT
);

  logic                 put;
  logic                 valid;
  logic                 eom;
  logic                 cmpl;
  logic                 parity;
  logic [PLD_WIDTH-1:0] payload;

  // producer side of the flit
  modport src (
    output put, valid, eom, cmpl, parity, payload
  );

  // consumer side of the flit
  modport dst (
    input put, valid, eom, cmpl, parity, payload
  );

endinterface

//--- design/sbtgt_flow_ctrl.sv
// pop decisions and np ordering fence for the two target queues, plus registered credits to the endpoint
`timescale 1ns/1ps

module sbtgt_flow_ctrl (
  input  logic              agent_clk,
  input  logic              agent_rst_b,
  input  logic              pc_head_put,
  input  logic              pc_head_valid,
  input  logic              pc_empty,
  input  logic              np_head_put,
  input  logic              np_head_valid,
  input  logic              np_empty,
  input  sbtgt_pkg::qptr_t  pc_head_tag,
  input  sbtgt_pkg::qptr_t  np_rptr,
  input  logic              ip_pc_free,
  input  logic              ip_np_free,
  input  logic              ip_np_claim,
  output logic              pc_pop,
  output logic              np_pop,
  output logic              np_fence_open,
  output logic              ep_pc_free,
  output logic              ep_np_free,
  output logic              ep_np_claim
);

  logic pc_ready;
  logic np_ready;

  // ------------------------------------------------------------
  // ordering fence
  // ------------------------------------------------------------

  // the posted head remembers where the np write pointer stood when it arrived;
  // once the np read pointer reaches that spot, the np head is younger and must wait
  assign np_fence_open = (pc_head_tag != np_rptr) | pc_empty | np_empty;

  // ------------------------------------------------------------
  // pops
  // ------------------------------------------------------------

  // put heads wait for free, valid-only heads go straight away
  assign pc_ready = pc_head_put ? ip_pc_free : pc_head_valid;
  assign np_ready = np_head_put ? ip_np_free : np_head_valid;

  assign pc_pop = pc_ready & ~pc_empty;
  assign np_pop = np_ready & np_fence_open & ~np_empty;

  // ------------------------------------------------------------
  // credits back to the endpoint
  // ------------------------------------------------------------

  always_ff @(posedge agent_clk or negedge agent_rst_b) begin
    if (!agent_rst_b) begin
      ep_pc_free  <= 1'b0;
      ep_np_free  <= 1'b0;
      ep_np_claim <= 1'b0;
    end else begin
      ep_pc_free  <= ip_pc_free;
      // hide np free while an older posted flit is still queued ahead
      ep_np_free  <= ip_np_free & np_fence_open;
      ep_np_claim <= ip_np_claim;
    end
  end

endmodule

//--- design/sbtgt_msg_tracker.sv
// per channel FSM that reports whether a message is still in progress at the agent
`timescale 1ns/1ps

module sbtgt_msg_tracker (
  input  logic agent_clk,
  input  logic agent_rst_b,
  input  logic beat,
  input  logic eom,
  input  logic last_byte,
  output logic msg_in_progress
);

  import sbtgt_pkg::*;

  msg_state_e state;
  msg_state_e state_nxt;

  // only a completed dword moves the state
  always_comb begin
    state_nxt = state;
    if (beat && last_byte) begin
      if (eom) begin
        state_nxt = msg_idle;
      end else begin
        state_nxt = msg_active;
      end
    end
  end

  always_ff @(posedge agent_clk or negedge agent_rst_b) begin
    if (!agent_rst_b) begin
      state <= msg_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign msg_in_progress = (state == msg_active);

endmodule

//--- design/sbtgt_pkg.sv
// shared types and defaults for the sideband target repeater, imported by every design module
package sbtgt_pkg;

  // ------------------------------------------------------------
  // widths with a meaning
  // ------------------------------------------------------------

  // bit 0 is the entry index, bit 1 the wrap bit
  typedef logic [1:0] qptr_t;

  // beat position inside a dword for narrow payloads
  typedef logic [1:0] beat_cnt_t;

  // ------------------------------------------------------------
  // enumerations
  // ------------------------------------------------------------

  typedef enum logic {
    msg_idle   = 1'b0,
    msg_active = 1'b1
  } msg_state_e;

  // index into the two-bit per channel status ports
  typedef enum int unsigned {
    chan_pc = 0,
    chan_np = 1
  } chan_e;

  // full dword payload unless the top level narrows it
  localparam int PLD_WIDTH_DEFAULT = 32;

endpackage

//--- design/sbtgt_queue.sv
// two-entry flit queue for one channel, with an optional ordering tag kept per entry
`timescale 1ns/1ps

module sbtgt_queue #(
  parameter int PLD_WIDTH = sbtgt_pkg::PLD_WIDTH_DEFAULT,
  parameter bit STORE_TAG = 1'b0
) (
  input  logic              agent_clk,
  input  logic              agent_rst_b,
  sbtgt_flit_if.dst         flit_in,
  input  logic              pop,
  input  sbtgt_pkg::qptr_t  tag_in,
  sbtgt_flit_if.src         head,
  output sbtgt_pkg::qptr_t  head_tag,
  output sbtgt_pkg::qptr_t  rptr,
  output sbtgt_pkg::qptr_t  wptr_next,
  output logic              empty,
  output logic              full
);

  import sbtgt_pkg::*;

  // cmpl, eom, valid, put, parity, payload
  localparam int ENTRY_W = PLD_WIDTH + 5;

  logic [ENTRY_W-1:0] mem [2];
  logic [ENTRY_W-1:0] entry_in;
  logic [ENTRY_W-1:0] entry_out;
  qptr_t              wptr;
  qptr_t              wptr_inc;
  qptr_t              rptr_inc;
  logic               push;
  logic               wr_move;
  logic               rd_move;

  // ------------------------------------------------------------
  // pointers and flags
  // ------------------------------------------------------------

  assign push    = flit_in.put | flit_in.valid;
  assign wr_move = push & ~full;
  assign rd_move = pop & ~empty;

  // depth two, so a plain increment flips the wrap bit after index 1
  assign wptr_inc = wptr + qptr_t'(1);
  assign rptr_inc = rptr + qptr_t'(1);

  // pointer as it stands after this cycle's push
  assign wptr_next = wr_move ? wptr_inc : wptr;

  always_ff @(posedge agent_clk or negedge agent_rst_b) begin
    if (!agent_rst_b) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (wr_move) begin
        wptr <= wptr_inc;
      end
      if (rd_move) begin
        rptr <= rptr_inc;
      end
    end
  end

  // full is set when a lone push catches up with the read index
  always_ff @(posedge agent_clk or negedge agent_rst_b) begin
    if (!agent_rst_b) begin
      full <= 1'b0;
    end else if (wr_move && !rd_move && (wptr_inc[0] == rptr[0])) begin
      full <= 1'b1;
    end else if (rd_move && !wr_move) begin
      full <= 1'b0;
    end
  end

  // empty is set when a lone pop catches up with the write index
  always_ff @(posedge agent_clk or negedge agent_rst_b) begin
    if (!agent_rst_b) begin
      empty <= 1'b1;
    end else if (rd_move && !wr_move && (rptr_inc[0] == wptr[0])) begin
      empty <= 1'b1;
    end else if (wr_move && !rd_move) begin
      empty <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  assign entry_in = {flit_in.cmpl, flit_in.eom, flit_in.valid, flit_in.put,
                     flit_in.parity, flit_in.payload};

  always_ff @(posedge agent_clk) begin
    if (wr_move) begin
      mem[wptr[0]] <= entry_in;
    end
  end

  assign entry_out = mem[rptr[0]];

  assign head.payload = entry_out[PLD_WIDTH-1:0];
  assign head.parity  = entry_out[PLD_WIDTH];
  assign head.put     = entry_out[PLD_WIDTH+1];
  assign head.valid   = entry_out[PLD_WIDTH+2];
  assign head.eom     = entry_out[PLD_WIDTH+3];
  assign head.cmpl    = entry_out[PLD_WIDTH+4];

  // np write pointer captured alongside each posted entry
  if (STORE_TAG) begin : g_tag
    qptr_t tag_mem [2];

    always_ff @(posedge agent_clk) begin
      if (wr_move) begin
        tag_mem[wptr[0]] <= tag_in;
      end
    end

    assign head_tag = tag_mem[rptr[0]];
  end else begin : g_no_tag
    assign head_tag = '0;
  end

endmodule

//--- design/sbtgt_repeater.sv
// target side repeater top, queuing endpoint flits per channel and presenting the heads to the agent
`timescale 1ns/1ps

module sbtgt_repeater #(
  parameter int PLD_WIDTH = sbtgt_pkg::PLD_WIDTH_DEFAULT
) (
  input  logic                 agent_clk,
  input  logic                 agent_rst_b,
  // agent side
  input  logic                 ip_pc_free,
  input  logic                 ip_np_free,
  input  logic                 ip_np_claim,
  output logic                 ip_pc_msgip,
  output logic                 ip_np_msgip,
  output logic                 ip_pc_eom,
  output logic                 ip_np_eom,
  output logic                 ip_pc_parity,
  output logic                 ip_np_parity,
  output logic                 ip_pc_cmpl,
  output logic                 ip_pc_valid,
  output logic                 ip_np_valid,
  output logic [PLD_WIDTH-1:0] ip_pc_payload,
  output logic [PLD_WIDTH-1:0] ip_np_payload,
  // endpoint side
  output logic                 ep_pc_free,
  output logic                 ep_np_free,
  output logic                 ep_np_claim,
  input  logic                 ep_pc_put,
  input  logic                 ep_np_put,
  input  logic                 ep_pc_valid,
  input  logic                 ep_np_valid,
  input  logic                 ep_pc_eom,
  input  logic                 ep_np_eom,
  input  logic                 ep_pc_parity,
  input  logic                 ep_np_parity,
  input  logic                 ep_pc_cmpl,
  input  logic [PLD_WIDTH-1:0] ep_pc_payload,
  input  logic [PLD_WIDTH-1:0] ep_np_payload,
  // status
  output logic [1:0]           queue_empty,
  output logic [1:0]           put_to_tgt,
  output logic                 np_fence_open
);

  import sbtgt_pkg::*;

  sbtgt_flit_if #(.PLD_WIDTH(PLD_WIDTH)) ep_pc_flit ();
  sbtgt_flit_if #(.PLD_WIDTH(PLD_WIDTH)) ep_np_flit ();
  sbtgt_flit_if #(.PLD_WIDTH(PLD_WIDTH)) ip_pc_head ();
  sbtgt_flit_if #(.PLD_WIDTH(PLD_WIDTH)) ip_np_head ();

  qptr_t pc_head_tag;
  qptr_t np_rptr;
  qptr_t np_wptr_next;
  logic  pc_empty;
  logic  np_empty;
  logic  pc_pop;
  logic  np_pop;
  logic  pc_beat;
  logic  np_beat;
  logic  pc_last_byte;
  logic  np_last_byte;

  // ------------------------------------------------------------
  // endpoint flits into the queues
  // ------------------------------------------------------------

  assign ep_pc_flit.put     = ep_pc_put;
  assign ep_pc_flit.valid   = ep_pc_valid;
  assign ep_pc_flit.eom     = ep_pc_eom;
  assign ep_pc_flit.cmpl    = ep_pc_cmpl;
  assign ep_pc_flit.parity  = ep_pc_parity;
  assign ep_pc_flit.payload = ep_pc_payload;

  // completions only travel on the posted channel
  assign ep_np_flit.put     = ep_np_put;
  assign ep_np_flit.valid   = ep_np_valid;
  assign ep_np_flit.eom     = ep_np_eom;
  assign ep_np_flit.cmpl    = 1'b0;
  assign ep_np_flit.parity  = ep_np_parity;
  assign ep_np_flit.payload = ep_np_payload;

  // posted entries are tagged with the np write pointer for the fence
  sbtgt_queue #(.PLD_WIDTH(PLD_WIDTH), .STORE_TAG(1'b1)) u_pc_queue (
    .agent_clk   (agent_clk),
    .agent_rst_b (agent_rst_b),
    .flit_in     (ep_pc_flit),
    .pop         (pc_pop),
    .tag_in      (np_wptr_next),
    .head        (ip_pc_head),
    .head_tag    (pc_head_tag),
    .rptr        (),
    .wptr_next   (),
    .empty       (pc_empty),
    .full        ()
  );

  sbtgt_queue #(.PLD_WIDTH(PLD_WIDTH), .STORE_TAG(1'b0)) u_np_queue (
    .agent_clk   (agent_clk),
    .agent_rst_b (agent_rst_b),
    .flit_in     (ep_np_flit),
    .pop         (np_pop),
    .tag_in      (),
    .head        (ip_np_head),
    .head_tag    (),
    .rptr        (np_rptr),
    .wptr_next   (np_wptr_next),
    .empty       (np_empty),
    .full        ()
  );

  // ------------------------------------------------------------
  // flow control
  // ------------------------------------------------------------

  sbtgt_flow_ctrl u_flow_ctrl (
    .agent_clk     (agent_clk),
    .agent_rst_b   (agent_rst_b),
    .pc_head_put   (ip_pc_head.put),
    .pc_head_valid (ip_pc_head.valid),
    .pc_empty      (pc_empty),
    .np_head_put   (ip_np_head.put),
    .np_head_valid (ip_np_head.valid),
    .np_empty      (np_empty),
    .pc_head_tag   (pc_head_tag),
    .np_rptr       (np_rptr),
    .ip_pc_free    (ip_pc_free),
    .ip_np_free    (ip_np_free),
    .ip_np_claim   (ip_np_claim),
    .pc_pop        (pc_pop),
    .np_pop        (np_pop),
    .np_fence_open (np_fence_open),
    .ep_pc_free    (ep_pc_free),
    .ep_np_free    (ep_np_free),
    .ep_np_claim   (ep_np_claim)
  );

  // ------------------------------------------------------------
  // message in progress tracking
  // ------------------------------------------------------------

  // a delivered put flit is one beat
  assign pc_beat = pc_pop & ip_pc_head.put;
  assign np_beat = np_pop & ip_np_head.put;

  sbtgt_byte_counter #(.PLD_WIDTH(PLD_WIDTH)) u_pc_bytes (
    .agent_clk   (agent_clk),
    .agent_rst_b (agent_rst_b),
    .beat        (pc_beat),
    .last_byte   (pc_last_byte)
  );

  sbtgt_byte_counter #(.PLD_WIDTH(PLD_WIDTH)) u_np_bytes (
    .agent_clk   (agent_clk),
    .agent_rst_b (agent_rst_b),
    .beat        (np_beat),
    .last_byte   (np_last_byte)
  );

  sbtgt_msg_tracker u_pc_msg (
    .agent_clk       (agent_clk),
    .agent_rst_b     (agent_rst_b),
    .beat            (pc_beat),
    .eom             (ip_pc_head.eom),
    .last_byte       (pc_last_byte),
    .msg_in_progress (ip_pc_msgip)
  );

  sbtgt_msg_tracker u_np_msg (
    .agent_clk       (agent_clk),
    .agent_rst_b     (agent_rst_b),
    .beat            (np_beat),
    .eom             (ip_np_head.eom),
    .last_byte       (np_last_byte),
    .msg_in_progress (ip_np_msgip)
  );

  // ------------------------------------------------------------
  // agent outputs
  // ------------------------------------------------------------

  assign ip_pc_eom     = ip_pc_head.eom;
  assign ip_np_eom     = ip_np_head.eom;
  assign ip_pc_parity  = ip_pc_head.parity;
  assign ip_np_parity  = ip_np_head.parity;
  assign ip_pc_payload = ip_pc_head.payload;
  assign ip_np_payload = ip_np_head.payload;

  // stale entries must not look like live flits
  assign ip_pc_valid = ip_pc_head.valid & ~pc_empty;
  assign ip_np_valid = ip_np_head.valid & ~np_empty;
  assign ip_pc_cmpl  = ip_pc_head.cmpl & ~pc_empty;

  assign queue_empty[chan_pc] = pc_empty;
  assign queue_empty[chan_np] = np_empty;
  assign put_to_tgt[chan_pc]  = ip_pc_head.put;
  assign put_to_tgt[chan_np]  = ip_np_head.put;

endmodule

//--- sbtgt_repeater.f
design/sbtgt_pkg.sv
design/sbtgt_flit_if.sv
design/sbtgt_queue.sv
design/sbtgt_byte_counter.sv
design/sbtgt_msg_tracker.sv
design/sbtgt_flow_ctrl.sv
design/sbtgt_repeater.sv
tests/sbtgt_tb.sv

//--- tests/sbtgt_input.txt
// columns: pc_ctl pc_pld np_ctl np_pld ip exp_queue_empty exp_msgip{np,pc}; ff in pc_ctl ends
// ctl bits: 0 put, 1 valid, 2 eom, 3 parity, 4 cmpl, 7 random payload; ip bits: 0 pc_free, 1 np_free, 2 np_claim
// reset state
00 00 00 00 00 03 00
00 00 00 00 00 03 00
// posted pass-through, four beats without eom
01 11 00 00 01 03 00
09 12 00 00 01 02 00
81 00 00 00 01 02 00
01 14 00 00 01 02 00
00 00 00 00 01 02 00
// second dword closes with eom, a valid-only completion in between
09 21 00 00 01 03 01
12 22 00 00 01 02 01
01 23 00 00 01 02 01
01 24 00 00 01 02 01
05 25 00 00 01 02 01
00 00 00 00 01 02 01
// back-pressure with pc free low
03 31 00 00 00 03 00
0b 32 00 00 00 02 00
00 00 00 00 00 02 00
00 00 00 00 00 02 00
00 00 00 00 01 02 00
00 00 00 00 01 02 00
// valid-only flits drain without free
02 41 00 00 00 03 00
1a 42 00 00 00 02 00
00 00 00 00 00 02 00
// np behind a posted flit is fenced
01 51 00 00 02 03 00
00 00 81 00 02 02 00
00 00 00 00 02 00 00
00 00 00 00 02 00 00
00 00 00 00 03 00 00
00 00 00 00 03 01 00
// np ahead of a posted flit is not held back
00 00 09 62 00 03 00
01 52 00 00 00 01 00
00 00 00 00 02 00 00
00 00 00 00 02 02 00
00 00 00 00 01 02 00
// same cycle pushes, then the np dword completes
05 53 05 63 00 03 01
00 00 00 00 00 00 01
00 00 00 00 03 00 01
00 00 01 64 00 03 01
00 00 00 00 06 01 01
00 00 00 00 04 03 03
00 00 00 00 00 03 03
ff 00 00 00 00 00 00

//--- tests/sbtgt_tb.sv
// self-checking testbench for the target repeater, replaying per cycle vectors against a queue model
`timescale 1ns/1ps

module sbtgt_tb;

  localparam int PLD_WIDTH    = 8;
  localparam int LINE_WORDS   = 7;
  localparam int NUM_LINES    = 41;
  localparam int DRAIN_LIMIT  = 50;
  localparam int BEATS_PER_DW = 32 / PLD_WIDTH;

  logic                 agent_clk;
  logic                 agent_rst_b;
  logic                 ip_pc_free;
  logic                 ip_np_free;
  logic                 ip_np_claim;
  logic                 ip_pc_msgip;
  logic                 ip_np_msgip;
  logic                 ip_pc_eom;
  logic                 ip_np_eom;
  logic                 ip_pc_parity;
  logic                 ip_np_parity;
  logic                 ip_pc_cmpl;
  logic                 ip_pc_valid;
  logic                 ip_np_valid;
  logic [PLD_WIDTH-1:0] ip_pc_payload;
  logic [PLD_WIDTH-1:0] ip_np_payload;
  logic                 ep_pc_free;
  logic                 ep_np_free;
  logic                 ep_np_claim;
  logic                 ep_pc_put;
  logic                 ep_np_put;
  logic                 ep_pc_valid;
  logic                 ep_np_valid;
  logic                 ep_pc_eom;
  logic                 ep_np_eom;
  logic                 ep_pc_parity;
  logic                 ep_np_parity;
  logic                 ep_pc_cmpl;
  logic [PLD_WIDTH-1:0] ep_pc_payload;
  logic [PLD_WIDTH-1:0] ep_np_payload;
  logic [1:0]           queue_empty;
  logic [1:0]           put_to_tgt;
  logic                 np_fence_open;

  logic [7:0] vec_mem [0:LINE_WORDS*NUM_LINES-1];

  // ------------------------------------------------------------
  // reference model state
  // ------------------------------------------------------------

  // entry layout {cmpl, eom, valid, put, parity, payload}
  logic [12:0] pc_q [$];
  logic [12:0] np_q [$];
  // np push count seen by each posted entry
  int          pc_tag_q [$];
  int          np_push_cnt;
  int          np_pop_cnt;
  int          pc_beats;
  int          np_beats;
  logic        pc_msgip_m;
  logic        np_msgip_m;
  logic        ep_pc_free_m;
  logic        ep_np_free_m;
  logic        ep_np_claim_m;
  logic        fence_exp;
  logic        pc_pop_exp;
  logic        np_pop_exp;

  sbtgt_repeater #(.PLD_WIDTH(PLD_WIDTH)) dut (.*);

  initial begin
    agent_clk = 1'b0;
    forever #2 agent_clk = ~agent_clk;
  end

  task automatic stop_on_error();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic logic [12:0] pack_entry(input logic put, input logic valid,
                                             input logic eom, input logic parity,
                                             input logic cmpl, input logic [7:0] pld);
    return {cmpl, eom, valid, put, parity, pld};
  endfunction

  // count one delivered put beat and close the dword on the last byte lane
  task automatic count_beat(inout int beats, inout logic msgip, input logic eom);
    if (beats == BEATS_PER_DW - 1) begin
      msgip = ~eom;
      beats = 0;
    end else begin
      beats++;
    end
  endtask

  task automatic apply_line(input int idx);
    logic [7:0] pc_ctl;
    logic [7:0] pc_pld;
    logic [7:0] np_ctl;
    logic [7:0] np_pld;
    logic [7:0] ip_ctl;
    pc_ctl = vec_mem[idx*LINE_WORDS];
    pc_pld = vec_mem[idx*LINE_WORDS+1];
    np_ctl = vec_mem[idx*LINE_WORDS+2];
    np_pld = vec_mem[idx*LINE_WORDS+3];
    ip_ctl = vec_mem[idx*LINE_WORDS+4];
    if (pc_ctl[7]) begin
      pc_pld = 8'($urandom);
    end
    if (np_ctl[7]) begin
      np_pld = 8'($urandom);
    end
    ep_pc_put     <= pc_ctl[0];
    ep_pc_valid   <= pc_ctl[1];
    ep_pc_eom     <= pc_ctl[2];
    ep_pc_parity  <= pc_ctl[3];
    ep_pc_cmpl    <= pc_ctl[4];
    ep_pc_payload <= pc_pld;
    ep_np_put     <= np_ctl[0];
    ep_np_valid   <= np_ctl[1];
    ep_np_eom     <= np_ctl[2];
    ep_np_parity  <= np_ctl[3];
    ep_np_payload <= np_pld;
    ip_pc_free    <= ip_ctl[0];
    ip_np_free    <= ip_ctl[1];
    ip_np_claim   <= ip_ctl[2];
  endtask

  // ------------------------------------------------------------
  // model prediction, checks and update
  // ------------------------------------------------------------

  task automatic predict_cycle();
    logic [12:0] pc_head;
    logic [12:0] np_head;
    pc_head = (pc_q.size() > 0) ? pc_q[0] : '0;
    np_head = (np_q.size() > 0) ? np_q[0] : '0;
    // an np head pushed after the posted head must wait for it
    fence_exp  = (pc_q.size() == 0) || (np_q.size() == 0) || (pc_tag_q[0] != np_pop_cnt);
    pc_pop_exp = (pc_q.size() > 0) && (pc_head[9] ? ip_pc_free : pc_head[10]);
    np_pop_exp = (np_q.size() > 0) && fence_exp && (np_head[9] ? ip_np_free : np_head[10]);
  endtask

  task automatic check_outputs(input logic [7:0] exp_qe, input logic [7:0] exp_m);
    logic [1:0] qe_m;
    qe_m = {np_q.size() == 0, pc_q.size() == 0};
    check_value("queue_empty", queue_empty, qe_m);
    check_value("queue_empty vector", queue_empty, exp_qe);
    check_value("ip_pc_msgip", ip_pc_msgip, pc_msgip_m);
    check_value("ip_np_msgip", ip_np_msgip, np_msgip_m);
    check_value("msgip vector", {ip_np_msgip, ip_pc_msgip}, exp_m);
    check_value("np_fence_open", np_fence_open, fence_exp);
    check_value("ep_pc_free", ep_pc_free, ep_pc_free_m);
    check_value("ep_np_free", ep_np_free, ep_np_free_m);
    check_value("ep_np_claim", ep_np_claim, ep_np_claim_m);
    check_value("ip_pc_valid", ip_pc_valid, (pc_q.size() > 0) && pc_q[0][10]);
    check_value("ip_pc_cmpl", ip_pc_cmpl, (pc_q.size() > 0) && pc_q[0][12]);
    check_value("ip_np_valid", ip_np_valid, (np_q.size() > 0) && np_q[0][10]);
    // head contents only mean something while the queue holds an entry
    if (pc_q.size() > 0) begin
      check_value("ip_pc_payload", ip_pc_payload, pc_q[0][7:0]);
      check_value("ip_pc_parity", ip_pc_parity, pc_q[0][8]);
      check_value("ip_pc_eom", ip_pc_eom, pc_q[0][11]);
      check_value("put_to_tgt[0]", put_to_tgt[0], pc_q[0][9]);
    end
    if (np_q.size() > 0) begin
      check_value("ip_np_payload", ip_np_payload, np_q[0][7:0]);
      check_value("ip_np_parity", ip_np_parity, np_q[0][8]);
      check_value("ip_np_eom", ip_np_eom, np_q[0][11]);
      check_value("put_to_tgt[1]", put_to_tgt[1], np_q[0][9]);
    end
  endtask

  task automatic advance_model();
    logic        pc_push;
    logic        np_push;
    logic [12:0] head;
    // a full queue refuses the push even if it pops this cycle
    pc_push = (ep_pc_put || ep_pc_valid) && (pc_q.size() < 2);
    np_push = (ep_np_put || ep_np_valid) && (np_q.size() < 2);
    ep_pc_free_m  = ip_pc_free;
    ep_np_free_m  = ip_np_free & fence_exp;
    ep_np_claim_m = ip_np_claim;
    if (pc_pop_exp) begin
      head = pc_q.pop_front();
      void'(pc_tag_q.pop_front());
      if (head[9]) begin
        count_beat(pc_beats, pc_msgip_m, head[11]);
      end
    end
    if (np_pop_exp) begin
      head = np_q.pop_front();
      np_pop_cnt++;
      if (head[9]) begin
        count_beat(np_beats, np_msgip_m, head[11]);
      end
    end
    // np pushes of the same cycle count as older than the posted flit
    if (np_push) begin
      np_q.push_back(pack_entry(ep_np_put, ep_np_valid, ep_np_eom, ep_np_parity,
                                1'b0, ep_np_payload));
      np_push_cnt++;
    end
    if (pc_push) begin
      pc_q.push_back(pack_entry(ep_pc_put, ep_pc_valid, ep_pc_eom, ep_pc_parity,
                                ep_pc_cmpl, ep_pc_payload));
      pc_tag_q.push_back(np_push_cnt);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    int   line;
    int   waited;
    logic done;
    agent_rst_b   = 1'b0;
    ip_pc_free    = 1'b0;
    ip_np_free    = 1'b0;
    ip_np_claim   = 1'b0;
    ep_pc_put     = 1'b0;
    ep_np_put     = 1'b0;
    ep_pc_valid   = 1'b0;
    ep_np_valid   = 1'b0;
    ep_pc_eom     = 1'b0;
    ep_np_eom     = 1'b0;
    ep_pc_parity  = 1'b0;
    ep_np_parity  = 1'b0;
    ep_pc_cmpl    = 1'b0;
    ep_pc_payload = '0;
    ep_np_payload = '0;
    np_push_cnt   = 0;
    np_pop_cnt    = 0;
    pc_beats      = 0;
    np_beats      = 0;
    pc_msgip_m    = 1'b0;
    np_msgip_m    = 1'b0;
    ep_pc_free_m  = 1'b0;
    ep_np_free_m  = 1'b0;
    ep_np_claim_m = 1'b0;
    void'($urandom(15));
    $readmemh("tests/sbtgt_input.txt", vec_mem);

    repeat (4) @(posedge agent_clk);
    agent_rst_b <= 1'b1;

    line = 0;
    done = 1'b0;
    while (!done && line < NUM_LINES) begin
      @(posedge agent_clk);
      if (vec_mem[line*LINE_WORDS] == 8'hff) begin
        done = 1'b1;
      end else begin
        apply_line(line);
        @(negedge agent_clk);
        predict_cycle();
        check_outputs(vec_mem[line*LINE_WORDS+5], vec_mem[line*LINE_WORDS+6]);
        advance_model();
        line++;
      end
    end

    // let anything still queued drain with free held high
    ep_pc_put   <= 1'b0;
    ep_np_put   <= 1'b0;
    ep_pc_valid <= 1'b0;
    ep_np_valid <= 1'b0;
    ip_pc_free  <= 1'b1;
    ip_np_free  <= 1'b1;
    waited = 0;
    @(negedge agent_clk);
    while (queue_empty !== 2'b11 && waited < DRAIN_LIMIT) begin
      @(negedge agent_clk);
      waited++;
    end
    if (queue_empty !== 2'b11) begin
      $display("Timeout: the queues did not drain within %0d cycles", DRAIN_LIMIT);
      stop_on_error();
    end

    $display("Regression passed");
    $finish;
  end

endmodule
